/* flist.f */
source/video_pkg.sv
source/apb_video_regs.sv
source/video_timing_gen.sv
source/pattern_gen.sv
source/tmds_encoder.sv
source/hdmi_out_top.sv
tb/hdmi_out_properties.sv
tb/hdmi_out_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= hdmi_out_tb
FLIST     ?= flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

/* tb/hdmi_out_tb.sv */
// top level testbench for hdmi_out_top, drives apb phases while the bound checker judges
module hdmi_out_tb
import video_pkg::*;
();

localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
// six phases of up to four frames each, plus slack for register traffic
localparam int CYCLE_LIMIT  = 6 * 4 * FRAME_CYCLES + 1000;

logic        pixel_clk = 1'b0;
logic        external_resetn;
apb_req_t    apb_req;
apb_rsp_t    apb_rsp;
tmds_lanes_t tmds;
int          seed = 35036;
int          cycles = 0;
int          tests_run = 0;
int          tests_failed = 0;
int          fails_at_start = 0;

hdmi_out_top u_hdmi_out_top (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .apb_req_i       (apb_req),
    .apb_rsp_o       (apb_rsp),
    .tmds_o          (tmds)
);

always #4 pixel_clk = ~pixel_clk;

always @(posedge pixel_clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end
end

task automatic wait_cycles(input int n);
    repeat (n) @(posedge pixel_clk);
endtask

task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] data);
    @(posedge pixel_clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge pixel_clk);
    #1;
    apb_req.penable = 1'b1;
    @(posedge pixel_clk);
    while (!apb_rsp.pready) @(posedge pixel_clk);
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
endtask

// park the raster, load mode and color, then restart from the origin
task automatic start_pattern(input pattern_mode_e mode, input logic [23:0] color);
    apb_access(1'b1, ADDR_CTRL, {29'b0, mode, 1'b0});
    apb_access(1'b1, ADDR_COLOR, {8'b0, color});
    wait_cycles(4);
    apb_access(1'b1, ADDR_CTRL, {29'b0, mode, 1'b1});
endtask

task automatic begin_phase();
    fails_at_start = u_hdmi_out_top.u_props.fail_cnt;
endtask

task automatic end_phase(input string name);
    int new_fails;
    new_fails = u_hdmi_out_top.u_props.fail_cnt - fails_at_start;
    tests_run++;
    if (new_fails != 0) begin
        tests_failed++;
        $display("FAIL at %0t: %s raised %0d assertion failures", $time, name, new_fails);
    end else begin
        $display("ok: %s", name);
    end
endtask

initial begin
    apb_req         = '0;
    external_resetn = 1'b0;
    wait_cycles(16);
    #3;
    external_resetn = 1'b1;

    begin_phase();
    apb_access(1'b1, ADDR_CTRL, 32'h4);
    apb_access(1'b0, ADDR_CTRL, 32'h0);
    apb_access(1'b1, ADDR_COLOR, 32'($random(seed)));
    apb_access(1'b0, ADDR_COLOR, 32'h0);
    apb_access(1'b1, ADDR_STATUS, 32'h55);
    apb_access(1'b0, 4'hC, 32'h0);
    apb_access(1'b1, 4'hC, 32'h7);
    apb_access(1'b0, ADDR_CTRL, 32'h0);
    apb_access(1'b0, ADDR_COLOR, 32'h0);
    end_phase("register access");

    begin_phase();
    wait_cycles(20);
    apb_access(1'b0, ADDR_STATUS, 32'h0);
    apb_access(1'b0, ADDR_CTRL, 32'h0);
    end_phase("disabled state");

    begin_phase();
    for (int m = 0; m < 4; m++) begin
        start_pattern(pattern_mode_e'(m), 24'h3c5a96);
        wait_cycles(FRAME_CYCLES + 4);
    end
    end_phase("sync placement");

    begin_phase();
    start_pattern(PAT_SOLID, 24'($random(seed)));
    wait_cycles(FRAME_CYCLES + 4);
    start_pattern(PAT_SOLID, 24'($random(seed)));
    wait_cycles(FRAME_CYCLES / 2);
    for (int m = 1; m < 4; m++) begin
        start_pattern(pattern_mode_e'(m), 24'h0);
        wait_cycles(FRAME_CYCLES / 2);
    end
    end_phase("pixel data");

    begin_phase();
    for (int i = 0; i < 3; i++) begin
        start_pattern(PAT_SOLID, 24'($random(seed)));
        wait_cycles(FRAME_CYCLES / 2);
    end
    start_pattern(PAT_H_RAMP, 24'h0);
    wait_cycles(FRAME_CYCLES / 2);
    end_phase("dc balance");

    begin_phase();
    start_pattern(PAT_COLOR_BARS, 24'h0);
    wait_cycles(3 * FRAME_CYCLES);
    apb_access(1'b0, ADDR_STATUS, 32'h0);
    end_phase("frame counting");

    $display("tests run %0d, failed %0d, assertion failures %0d",
             tests_run, tests_failed, u_hdmi_out_top.u_props.fail_cnt);
    if (tests_failed == 0 && u_hdmi_out_top.u_props.fail_cnt == 0) begin
        $display("TEST PASS");
    end else begin
        $display("TEST FAIL");
    end
    $finish;
end

endmodule

/* tb/hdmi_out_properties.sv */
// bound checker for hdmi_out_top, keeps a port level reference model and flags mismatches
module hdmi_out_properties
import video_pkg::*;
(
    input logic        pixel_clk,
    input logic        external_resetn,
    input apb_req_t    apb_req_i,
    input apb_rsp_t    apb_rsp_o,
    input tmds_lanes_t tmds_o
);

// control symbols written out from the dvi table
localparam logic [9:0] SYM_C00 = 10'b1101010100;
localparam logic [9:0] SYM_C01 = 10'b0010101011;
localparam logic [9:0] SYM_C10 = 10'b0101010100;
localparam logic [9:0] SYM_C11 = 10'b1010101011;

int          fail_cnt = 0;
logic        m_en;
logic [1:0]  m_mode;
logic [23:0] m_color;
logic        ever_en;
int          run_cnt;
int          off_cnt;
int          frames;
int          bal0;
int          bal1;
int          bal2;
logic        access;
logic        err_exp;
int          pos;
int          px;
int          py;
logic        m_de;
logic        m_hs;
logic        m_vs;
logic        data_chk;
logic        blank_chk;
logic [7:0]  exp_r;
logic [7:0]  exp_g;
logic [7:0]  exp_b;
logic [9:0]  exp_ctrl;

function automatic logic [7:0] decode_symbol(input logic [9:0] s);
    logic [7:0] d;
    logic [7:0] o;
    d = s[9] ? ~s[7:0] : s[7:0];
    o[0] = d[0];
    for (int i = 1; i < 8; i++) begin
        o[i] = s[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return o;
endfunction

function automatic int ones_minus_zeros(input logic [9:0] s);
    return 2 * $countones(s) - 10;
endfunction

always_comb begin
    access  = apb_req_i.psel && apb_req_i.penable;
    err_exp = access && !(apb_req_i.paddr == 4'h0 || apb_req_i.paddr == 4'h4 ||
              (apb_req_i.paddr == 4'h8 && !apb_req_i.pwrite));
    // symbol on the lanes belongs to raster position run_cnt - 3
    pos  = run_cnt - 3;
    px   = pos % H_TOTAL;
    py   = (pos / H_TOTAL) % V_TOTAL;
    m_de = (px < H_ACTIVE) && (py < V_ACTIVE);
    m_hs = (px >= H_ACTIVE + H_FP) && (px < H_ACTIVE + H_FP + H_SYNC);
    m_vs = (py >= V_ACTIVE + V_FP) && (py < V_ACTIVE + V_FP + V_SYNC);
    data_chk  = m_en && run_cnt >= 3 && m_de;
    blank_chk = m_en && run_cnt >= 3 && !m_de;
    case (m_mode)
        2'd0: {exp_r, exp_g, exp_b} = m_color;
        2'd1: {exp_r, exp_g, exp_b} = {3{8'(px * 16)}};
        2'd2: begin
            exp_r = ((px / 2) & 1) != 0 ? 8'hff : 8'h00;
            exp_g = ((px / 2) & 2) != 0 ? 8'hff : 8'h00;
            exp_b = ((px / 2) & 4) != 0 ? 8'hff : 8'h00;
        end
        default: {exp_r, exp_g, exp_b} = (((px >> 1) ^ (py >> 1)) & 1) != 0 ? '1 : '0;
    endcase
    case ({m_vs, m_hs})
        2'b00:   exp_ctrl = SYM_C00;
        2'b01:   exp_ctrl = SYM_C01;
        2'b10:   exp_ctrl = SYM_C10;
        default: exp_ctrl = SYM_C11;
    endcase
end

always_ff @(posedge pixel_clk or negedge external_resetn) begin
    if (!external_resetn) begin
        m_en    <= 1'b0;
        m_mode  <= '0;
        m_color <= '0;
        ever_en <= 1'b0;
        run_cnt <= 0;
        off_cnt <= 3;
        frames  <= 0;
        bal0    <= 0;
        bal1    <= 0;
        bal2    <= 0;
    end else begin
        if (access && apb_req_i.pwrite && !err_exp) begin
            if (apb_req_i.paddr == 4'h0) begin
                m_en   <= apb_req_i.pwdata[0];
                m_mode <= apb_req_i.pwdata[2:1];
                if (apb_req_i.pwdata[0]) begin
                    ever_en <= 1'b1;
                end
            end else begin
                m_color <= apb_req_i.pwdata[23:0];
            end
        end
        run_cnt <= m_en ? run_cnt + 1 : 0;
        off_cnt <= m_en ? 0 : (off_cnt < 3 ? off_cnt + 1 : 3);
        // frame start seen by the counter one cycle after raster origin
        if (m_en && run_cnt >= 1 && (run_cnt - 1) % (H_TOTAL * V_TOTAL) == 0) begin
            frames <= frames + 1;
        end
        bal0 <= data_chk ? bal0 + ones_minus_zeros(tmds_o.lane0) : 0;
        bal1 <= data_chk ? bal1 + ones_minus_zeros(tmds_o.lane1) : 0;
        bal2 <= data_chk ? bal2 + ones_minus_zeros(tmds_o.lane2) : 0;
    end
end

a_ready: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    access |-> apb_rsp_o.pready)
    else begin fail_cnt++; $error("pready low in access phase"); end

a_slverr: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    access |-> apb_rsp_o.pslverr == err_exp)
    else begin fail_cnt++; $error("pslverr wrong for addr %h", apb_req_i.paddr); end

a_ctrl_read: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    (access && !apb_req_i.pwrite && apb_req_i.paddr == 4'h0) |->
    apb_rsp_o.prdata == {29'b0, m_mode, m_en})
    else begin fail_cnt++; $error("CTRL read %h", apb_rsp_o.prdata); end

a_color_read: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    (access && !apb_req_i.pwrite && apb_req_i.paddr == 4'h4) |->
    apb_rsp_o.prdata == {8'b0, m_color})
    else begin fail_cnt++; $error("COLOR read %h", apb_rsp_o.prdata); end

a_status_read: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    (access && !apb_req_i.pwrite && apb_req_i.paddr == 4'h8) |->
    (ever_en ? (int'(apb_rsp_o.prdata) + 1 >= frames && int'(apb_rsp_o.prdata) <= frames + 1)
             : apb_rsp_o.prdata == '0))
    else begin fail_cnt++; $error("STATUS read %0d, expected %0d", apb_rsp_o.prdata, frames); end

a_idle: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    (!m_en && off_cnt >= 3) |->
    (tmds_o.lane0 == SYM_C00 && tmds_o.lane1 == SYM_C00 && tmds_o.lane2 == SYM_C00))
    else begin fail_cnt++; $error("lanes not idle while disabled"); end

a_blank: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    blank_chk |->
    (tmds_o.lane0 == exp_ctrl && tmds_o.lane1 == SYM_C00 && tmds_o.lane2 == SYM_C00))
    else begin fail_cnt++; $error("blanking symbol wrong at x=%0d y=%0d", px, py); end

a_pixel: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    data_chk |->
    (decode_symbol(tmds_o.lane0) == exp_b && decode_symbol(tmds_o.lane1) == exp_g &&
     decode_symbol(tmds_o.lane2) == exp_r))
    else begin fail_cnt++; $error("pixel wrong at x=%0d y=%0d", px, py); end

a_balance: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
    (bal0 >= -8 && bal0 <= 8 && bal1 >= -8 && bal1 <= 8 && bal2 >= -8 && bal2 <= 8))
    else begin fail_cnt++; $error("disparity out of range %0d %0d %0d", bal0, bal1, bal2); end

endmodule

bind hdmi_out_top hdmi_out_properties u_props (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .apb_req_i       (apb_req_i),
    .apb_rsp_o       (apb_rsp_o),
    .tmds_o          (tmds_o)
);

/* source/hdmi_out_top.sv */
// pixel domain hdmi output, apb configured, producing three tmds symbol lanes
module hdmi_out_top
import video_pkg::*;
(
    input  logic        pixel_clk,
    input  logic        external_resetn,

    input  apb_req_t    apb_req_i,
    output apb_rsp_t    apb_rsp_o,

    output tmds_lanes_t tmds_o
);

video_cfg_t cfg;
timing_t    raster;
timing_t    pix_timing;
rgb_t       pixel;
logic       frame_start;

apb_video_regs u_apb_video_regs (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .apb_req_i       (apb_req_i),
    .frame_start_i   (frame_start),
    .apb_rsp_o       (apb_rsp_o),
    .cfg_o           (cfg)
);

video_timing_gen u_video_timing_gen (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .enable_i        (cfg.enable),
    .timing_o        (raster),
    .frame_start_o   (frame_start)
);

pattern_gen u_pattern_gen (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .cfg_i           (cfg),
    .timing_i        (raster),
    .pixel_o         (pixel),
    .timing_o        (pix_timing)
);

// syncs ride on the blue lane only
tmds_encoder u_tmds_lane0 (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .data_i          (pixel.blue),
    .c0_i            (pix_timing.hsync),
    .c1_i            (pix_timing.vsync),
    .de_i            (pix_timing.de),
    .symbol_o        (tmds_o.lane0)
);

tmds_encoder u_tmds_lane1 (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .data_i          (pixel.green),
    .c0_i            (1'b0),
    .c1_i            (1'b0),
    .de_i            (pix_timing.de),
    .symbol_o        (tmds_o.lane1)
);

tmds_encoder u_tmds_lane2 (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .data_i          (pixel.red),
    .c0_i            (1'b0),
    .c1_i            (1'b0),
    .de_i            (pix_timing.de),
    .symbol_o        (tmds_o.lane2)
);

endmodule

/* source/tmds_encoder.sv */
// single lane tmds 8b/10b encoder, instantiated once per color channel
module tmds_encoder
import video_pkg::*;
(
    input  logic       pixel_clk,
    input  logic       external_resetn,

    input  logic [7:0] data_i,
    input  logic       c0_i,
    input  logic       c1_i,
    input  logic       de_i,

    output logic [9:0] symbol_o
);

logic [8:0]        q_m;
logic [3:0]        n1_data;
logic [3:0]        n1_qm;
logic              use_xnor;
logic signed [5:0] balance;
logic signed [5:0] disparity;
logic signed [5:0] disparity_d;
logic [9:0]        symbol_d;
logic [9:0]        ctrl_sym;

function automatic logic [3:0] count_ones(input logic [7:0] v);
    logic [3:0] n;
    n = '0;
    for (int i = 0; i < 8; i++) begin
        n = n + {3'b0, v[i]};
    end
    return n;
endfunction

assign n1_data  = count_ones(data_i);
assign use_xnor = (n1_data > 4'd4) || ((n1_data == 4'd4) && !data_i[0]);

// stage 1, transition minimization
always_comb begin
    q_m[0] = data_i[0];
    for (int i = 1; i < 8; i++) begin
        q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_i[i]) : (q_m[i-1] ^ data_i[i]);
    end
    q_m[8] = ~use_xnor;
end

assign n1_qm   = count_ones(q_m[7:0]);
// ones minus zeros of the minimized byte
assign balance = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8;

// stage 2, dc balancing against the running disparity
always_comb begin
    if (disparity == 6'sd0 || balance == 6'sd0) begin
        symbol_d = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
        if (q_m[8]) begin
            disparity_d = disparity + balance;
        end else begin
            disparity_d = disparity - balance;
        end
    end else if ((disparity > 6'sd0 && balance > 6'sd0) ||
                 (disparity < 6'sd0 && balance < 6'sd0)) begin
        // invert to pull the disparity back toward zero
        symbol_d    = {1'b1, q_m[8], ~q_m[7:0]};
        disparity_d = disparity + $signed({4'b0, q_m[8], 1'b0}) - balance;
    end else begin
        symbol_d    = {1'b0, q_m[8], q_m[7:0]};
        disparity_d = disparity - $signed({4'b0, ~q_m[8], 1'b0}) + balance;
    end
end

always_comb begin
    case ({c1_i, c0_i})
        2'b00:   ctrl_sym = TMDS_CTRL_00;
        2'b01:   ctrl_sym = TMDS_CTRL_01;
        2'b10:   ctrl_sym = TMDS_CTRL_10;
        default: ctrl_sym = TMDS_CTRL_11;
    endcase
end

always_ff @(posedge pixel_clk or negedge external_resetn) begin
    if (!external_resetn) begin
        symbol_o  <= TMDS_CTRL_00;
        disparity <= '0;
    end else if (de_i) begin
        symbol_o  <= symbol_d;
        disparity <= disparity_d;
    end else begin
        // blanking restarts the balance from zero
        symbol_o  <= ctrl_sym;
        disparity <= '0;
    end
end

endmodule

/* source/pattern_gen.sv */
// test pattern source, one register stage for pixel and timing together
module pattern_gen
import video_pkg::*;
(
    input  logic       pixel_clk,
    input  logic       external_resetn,

    input  video_cfg_t cfg_i,
    input  timing_t    timing_i,

    output rgb_t       pixel_o,
    output timing_t    timing_o
);

rgb_t       pix_d;
logic [2:0] bar_idx;
logic [7:0] ramp;
logic       check_on;

// two pixels per bar
assign bar_idx  = timing_i.x[3:1];
assign ramp     = {timing_i.x[3:0], 4'b0000};
assign check_on = timing_i.x[1] ^ timing_i.y[1];

always_comb begin
    pix_d = '0;
    if (timing_i.de) begin
        case (cfg_i.mode)
            PAT_SOLID: begin
                pix_d = rgb_t'(cfg_i.color);
            end
            PAT_H_RAMP: begin
                pix_d.red   = ramp;
                pix_d.green = ramp;
                pix_d.blue  = ramp;
            end
            PAT_COLOR_BARS: begin
                pix_d.red   = {8{bar_idx[0]}};
                pix_d.green = {8{bar_idx[1]}};
                pix_d.blue  = {8{bar_idx[2]}};
            end
            PAT_CHECKER: begin
                pix_d = {24{check_on}};
            end
            default: begin
                pix_d = '0;
            end
        endcase
    end
end

// pixel and its timing leave on the same edge
always_ff @(posedge pixel_clk or negedge external_resetn) begin
    if (!external_resetn) begin
        pixel_o  <= '0;
        timing_o <= '0;
    end else begin
        pixel_o  <= pix_d;
        timing_o <= timing_i;
    end
end

endmodule

/* source/video_timing_gen.sv */
// raster counters that produce registered syncs, data enable and pixel position
module video_timing_gen
import video_pkg::*;
(
    input  logic    pixel_clk,
    input  logic    external_resetn,

    input  logic    enable_i,

    output timing_t timing_o,
    output logic    frame_start_o
);

logic [POS_W-1:0] h_cnt;
logic [POS_W-1:0] v_cnt;
timing_t          timing_d;
logic             line_end;
logic             frame_end;

assign line_end  = (h_cnt == POS_W'(H_TOTAL - 1));
assign frame_end = (v_cnt == POS_W'(V_TOTAL - 1));

// decode the current counter position
always_comb begin
    timing_d.x     = h_cnt;
    timing_d.y     = v_cnt;
    timing_d.de    = (h_cnt < POS_W'(H_ACTIVE)) && (v_cnt < POS_W'(V_ACTIVE));
    timing_d.hsync = (h_cnt >= POS_W'(H_ACTIVE + H_FP)) &&
                     (h_cnt <  POS_W'(H_ACTIVE + H_FP + H_SYNC));
    timing_d.vsync = (v_cnt >= POS_W'(V_ACTIVE + V_FP)) &&
                     (v_cnt <  POS_W'(V_ACTIVE + V_FP + V_SYNC));
end

always_ff @(posedge pixel_clk or negedge external_resetn) begin
    if (!external_resetn) begin
        h_cnt         <= '0;
        v_cnt         <= '0;
        timing_o      <= '0;
        frame_start_o <= 1'b0;
    end else if (!enable_i) begin
        // parked at origin, all syncs low
        h_cnt         <= '0;
        v_cnt         <= '0;
        timing_o      <= '0;
        frame_start_o <= 1'b0;
    end else begin
        timing_o      <= timing_d;
        frame_start_o <= (h_cnt == '0) && (v_cnt == '0);

        if (line_end) begin
            h_cnt <= '0;
            if (frame_end) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end
end

endmodule

/* source/apb_video_regs.sv */
// apb slave with the video control, solid color and frame count registers
module apb_video_regs
import video_pkg::*;
(
    input  logic       pixel_clk,
    input  logic       external_resetn,

    input  apb_req_t   apb_req_i,
    input  logic       frame_start_i,

    output apb_rsp_t   apb_rsp_o,
    output video_cfg_t cfg_o
);

video_cfg_t        cfg_q;
logic [APB_DW-1:0] frame_cnt;
logic [APB_DW-1:0] rdata;
logic              access;
logic              addr_ok;
logic              slv_err;
logic              wr_en;

// zero wait states, so every access phase completes on this edge
assign access  = apb_req_i.psel & apb_req_i.penable;

assign addr_ok = (apb_req_i.paddr == ADDR_CTRL) ||
                 (apb_req_i.paddr == ADDR_COLOR) ||
                 (apb_req_i.paddr == ADDR_STATUS);

// status is read only
assign slv_err = access &&
                 (!addr_ok || (apb_req_i.pwrite && apb_req_i.paddr == ADDR_STATUS));

assign wr_en   = access && apb_req_i.pwrite && !slv_err;

always_ff @(posedge pixel_clk or negedge external_resetn) begin
    if (!external_resetn) begin
        cfg_q <= '0;
    end else if (wr_en) begin
        case (apb_req_i.paddr)
            ADDR_CTRL: begin
                cfg_q.enable <= apb_req_i.pwdata[0];
                cfg_q.mode   <= pattern_mode_e'(apb_req_i.pwdata[2:1]);
            end
            ADDR_COLOR: begin
                cfg_q.color <= apb_req_i.pwdata[23:0];
            end
            default: begin
                cfg_q <= cfg_q;
            end
        endcase
    end
end

// free running, wraps at 32 bits
always_ff @(posedge pixel_clk or negedge external_resetn) begin
    if (!external_resetn) begin
        frame_cnt <= '0;
    end else if (frame_start_i) begin
        frame_cnt <= frame_cnt + 1'b1;
    end
end

always_comb begin
    case (apb_req_i.paddr)
        ADDR_CTRL:   rdata = {29'b0, cfg_q.mode, cfg_q.enable};
        ADDR_COLOR:  rdata = {8'b0, cfg_q.color};
        ADDR_STATUS: rdata = frame_cnt;
        default:     rdata = '0;
    endcase
end

// read data only driven in the access phase of a read
assign apb_rsp_o.prdata  = (access && !apb_req_i.pwrite) ? rdata : '0;
assign apb_rsp_o.pready  = 1'b1;
assign apb_rsp_o.pslverr = slv_err;

assign cfg_o = cfg_q;

endmodule

/* source/video_pkg.sv */
// shared raster constants, register map, bus and pixel types for the hdmi video path
package video_pkg;

    // horizontal raster, in pixel clocks
    localparam int H_ACTIVE = 16;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

    // vertical raster, in lines
    localparam int V_ACTIVE = 8;
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam int POS_W = 5;

    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] ADDR_CTRL   = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_COLOR  = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 4'h8;

    // tmds control symbols, indexed by {c1, c0}
    localparam logic [9:0] TMDS_CTRL_00 = 10'b1101010100;
    localparam logic [9:0] TMDS_CTRL_01 = 10'b0010101011;
    localparam logic [9:0] TMDS_CTRL_10 = 10'b0101010100;
    localparam logic [9:0] TMDS_CTRL_11 = 10'b1010101011;

    typedef enum logic [1:0] {
        PAT_SOLID      = 2'd0,
        PAT_H_RAMP     = 2'd1,
        PAT_COLOR_BARS = 2'd2,
        PAT_CHECKER    = 2'd3
    } pattern_mode_e;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic          enable;
        pattern_mode_e mode;
        logic [23:0]   color;
    } video_cfg_t;

    typedef struct packed {
        logic             hsync;
        logic             vsync;
        logic             de;
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
    } timing_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // lane0 blue, lane1 green, lane2 red
    typedef struct packed {
        logic [9:0] lane0;
        logic [9:0] lane1;
        logic [9:0] lane2;
    } tmds_lanes_t;

endpackage
